//--- sim.f
+incdir+.
isa_pkg.sv
pipe_pkg.sv
register_file.sv
fetch_stage.sv
decode_stage.sv
execute_stage.sv
writeback_stage.sv
pipeline_cpu.sv
pipeline_cpu_tb.sv

//--- pipeline_cpu_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "cpu_config.svh"

module pipeline_cpu_tb import pipe_pkg::*; ();

    localparam int PROG_LEN = 24;
    localparam int EXP_LEN  = 24;
    localparam int WATCHDOG_NS = (EXP_LEN * 20 + 100) * 10;

    localparam logic [31:0] NOP_WORD = 32'h0000_0013;   // addi x0, x0, 0

    // funct7 and funct3 of the register ops
    localparam logic [9:0] K_ADD = 10'b0000000_000;
    localparam logic [9:0] K_SUB = 10'b0100000_000;
    localparam logic [9:0] K_SLT = 10'b0000000_010;
    localparam logic [9:0] K_XOR = 10'b0000000_100;
    localparam logic [9:0] K_OR  = 10'b0000000_110;
    localparam logic [9:0] K_AND = 10'b0000000_111;

    logic             clk;
    logic             rst;
    fetch_req_t       imem_req;
    logic [`XLEN-1:0] imem_rdata;
    logic             retire_valid;
    retire_t          retire;
    logic             retire_credit;

    logic [31:0] prog    [PROG_LEN];
    retire_t     exp_tab [EXP_LEN];

    logic             last_valid;   // request seen in the previous cycle
    logic [`XLEN-1:0] last_addr;
    logic             seen_req;
    logic [15:0]      lfsr;
    int               n_checked;
    int               credited;
    int               owed;         // entries consumed but not yet credited

    pipeline_cpu pipeline_cpu_i (
        .clk           ( clk ),
        .rst           ( rst ),
        .imem_req      ( imem_req ),
        .imem_rdata    ( imem_rdata ),
        .retire_valid  ( retire_valid ),
        .retire        ( retire ),
        .retire_credit ( retire_credit )
    );

    function automatic logic [31:0] alu_rr(input logic [9:0] kind,
                                           input logic [`REG_BITS-1:0] rd,
                                           input logic [`REG_BITS-1:0] rs1,
                                           input logic [`REG_BITS-1:0] rs2);
        return {kind[9:3], rs2, rs1, kind[2:0], rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] addi(input logic [`REG_BITS-1:0] rd,
                                         input logic [`REG_BITS-1:0] rs1,
                                         input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] lui(input logic [`REG_BITS-1:0] rd,
                                        input logic [19:0] imm);
        return {imm, rd, 7'b0110111};
    endfunction

    function automatic logic [31:0] jal(input logic [`REG_BITS-1:0] rd,
                                        input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    function automatic logic [31:0] word_at(input logic [`XLEN-1:0] addr);
        int idx;
        idx = int'(addr >> 2);
        return (idx < PROG_LEN) ? prog[idx] : NOP_WORD;
    endfunction

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    function automatic string retire_text(input retire_t r);
        return $sformatf("pc=%h rd=%0d wen=%b data=%h", r.pc, r.rd, r.wen, r.data);
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1, "run aborted");
    endtask

    task automatic check_retire(input retire_t got, input retire_t exp);
        // data of a retire without a write is don't care
        if (got.pc !== exp.pc || got.rd !== exp.rd || got.wen !== exp.wen ||
            (exp.wen && got.data !== exp.data)) begin
            abort_run($sformatf("Fail at %0t: retire got %s, expected %s",
                                $time, retire_text(got), retire_text(exp)));
        end
    endtask

    task automatic check_fetch(input fetch_req_t got, input fetch_req_t exp);
        if (got !== exp) begin
            abort_run($sformatf(
                "Fail at %0t: imem_req got valid=%b addr=%h, expected valid=%b addr=%h",
                $time, got.valid, got.addr, exp.valid, exp.addr));
        end
    endtask

    task automatic load_tables();
        prog[0]  = addi(5'd1, 5'd0, 12'd5);
        prog[1]  = addi(5'd2, 5'd0, 12'hFFD);        // -3
        prog[2]  = lui(5'd3, 20'h12345);
        prog[3]  = addi(5'd0, 5'd1, 12'd7);          // write to x0 is dropped
        prog[4]  = alu_rr(K_ADD, 5'd4, 5'd1, 5'd2);
        prog[5]  = alu_rr(K_SUB, 5'd5, 5'd1, 5'd2);
        prog[6]  = alu_rr(K_AND, 5'd6, 5'd1, 5'd2);
        prog[7]  = alu_rr(K_OR, 5'd7, 5'd1, 5'd2);
        prog[8]  = alu_rr(K_XOR, 5'd8, 5'd1, 5'd2);
        prog[9]  = alu_rr(K_SLT, 5'd9, 5'd2, 5'd1);  // -3 < 5
        prog[10] = alu_rr(K_SLT, 5'd10, 5'd1, 5'd2);
        prog[11] = alu_rr(K_ADD, 5'd11, 5'd0, 5'd1);
        prog[12] = addi(5'd12, 5'd1, 12'd10);        // dependent chain starts
        prog[13] = addi(5'd12, 5'd12, 12'd1);
        prog[14] = alu_rr(K_ADD, 5'd13, 5'd12, 5'd12);
        prog[15] = alu_rr(K_SUB, 5'd14, 5'd13, 5'd1);
        prog[16] = lui(5'd15, 20'hFFFFF);
        prog[17] = addi(5'd15, 5'd15, 12'h7FF);
        prog[18] = jal(5'd16, 21'd12);               // skips the next two
        prog[19] = addi(5'd17, 5'd0, 12'd1);
        prog[20] = addi(5'd18, 5'd0, 12'd2);
        prog[21] = alu_rr(K_ADD, 5'd17, 5'd16, 5'd15);
        prog[22] = 32'h0000_0073;                    // ecall, not supported
        prog[23] = alu_rr(K_SLT, 5'd18, 5'd15, 5'd16);

        exp_tab[0]  = '{32'h00, 5'd1, 1'b1, 32'd5};
        exp_tab[1]  = '{32'h04, 5'd2, 1'b1, 32'hFFFF_FFFD};
        exp_tab[2]  = '{32'h08, 5'd3, 1'b1, 32'h1234_5000};
        exp_tab[3]  = '{32'h0C, 5'd0, 1'b0, 32'd0};
        exp_tab[4]  = '{32'h10, 5'd4, 1'b1, 32'd2};
        exp_tab[5]  = '{32'h14, 5'd5, 1'b1, 32'd8};
        exp_tab[6]  = '{32'h18, 5'd6, 1'b1, 32'd5};
        exp_tab[7]  = '{32'h1C, 5'd7, 1'b1, 32'hFFFF_FFFD};
        exp_tab[8]  = '{32'h20, 5'd8, 1'b1, 32'hFFFF_FFF8};
        exp_tab[9]  = '{32'h24, 5'd9, 1'b1, 32'd1};
        exp_tab[10] = '{32'h28, 5'd10, 1'b1, 32'd0};
        exp_tab[11] = '{32'h2C, 5'd11, 1'b1, 32'd5};
        exp_tab[12] = '{32'h30, 5'd12, 1'b1, 32'd15};
        exp_tab[13] = '{32'h34, 5'd12, 1'b1, 32'd16};
        exp_tab[14] = '{32'h38, 5'd13, 1'b1, 32'd32};
        exp_tab[15] = '{32'h3C, 5'd14, 1'b1, 32'd27};
        exp_tab[16] = '{32'h40, 5'd15, 1'b1, 32'hFFFF_F000};
        exp_tab[17] = '{32'h44, 5'd15, 1'b1, 32'hFFFF_F7FF};
        exp_tab[18] = '{32'h48, 5'd16, 1'b1, 32'h0000_004C};   // link value
        exp_tab[19] = '{32'h54, 5'd17, 1'b1, 32'hFFFF_F84B};   // jump target
        exp_tab[20] = '{32'h58, 5'd0, 1'b0, 32'd0};
        exp_tab[21] = '{32'h5C, 5'd18, 1'b1, 32'd1};
        exp_tab[22] = '{32'h60, 5'd0, 1'b0, 32'd0};            // past the table
        exp_tab[23] = '{32'h64, 5'd0, 1'b0, 32'd0};
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        rst           = 1'b0;
        imem_rdata    = '0;
        retire_credit = 1'b0;
        last_valid    = 1'b0;
        last_addr     = '0;
        seen_req      = 1'b0;
        lfsr          = 16'd28;
        n_checked     = 0;
        credited      = 0;
        owed          = 0;
        load_tables();
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;
        wait (n_checked == EXP_LEN);
        $display("Test completed successfully");
        $finish;
    end

    // memory answer, retire checks and credits, all on the falling edge
    always @(negedge clk) begin
        if (rst) begin
            imem_rdata = last_valid ? word_at(last_addr) : '0;
            last_valid = imem_req.valid;
            last_addr  = imem_req.addr;
            if (imem_req.valid && !seen_req) begin
                check_fetch(imem_req, fetch_req_t'{valid: 1'b1, addr: `RESET_PC});
                seen_req = 1'b1;
            end
            if (retire_valid) begin
                if (!seen_req) begin
                    abort_run("a retire appeared before the first instruction request");
                end
                if (n_checked - credited >= `RETIRE_CREDITS) begin
                    abort_run("a retire appeared with no retire credit left");
                end
                if (n_checked < EXP_LEN) begin
                    check_retire(retire, exp_tab[n_checked]);
                end
                n_checked++;
            end
            retire_credit = 1'b0;
            if (owed > 0) begin
                if (lfsr[0]) begin
                    retire_credit = 1'b1;
                    owed--;
                    credited++;
                end
                lfsr = lfsr_next(lfsr);
            end
            if (retire_valid) begin
                owed++;   // consumer frees it from the next cycle on
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        abort_run("timeout, the pipeline stopped retiring instructions");
    end

endmodule

`default_nettype wire

//--- pipeline_cpu.sv
`timescale 1ns/100ps
`default_nettype none

`include "cpu_config.svh"

module pipeline_cpu import pipe_pkg::*; (
    input  wire              clk,
    input  wire              rst,
    output fetch_req_t       imem_req,
    input  wire [`XLEN-1:0]  imem_rdata,
    output logic             retire_valid,
    output retire_t          retire,
    input  wire              retire_credit
);
    fetch_out_t           fetch_out;
    decode_out_t          decode_out;
    exec_out_t            exec_out;
    reg_write_t           wr;

    logic                 fetch_stall;
    logic                 decode_stall;
    logic                 exec_stall;
    logic                 redirect;
    logic [`XLEN-1:0]     redirect_pc;

    logic [`REG_BITS-1:0] rs1;
    logic [`REG_BITS-1:0] rs2;
    logic [`XLEN-1:0]     rdata1;
    logic [`XLEN-1:0]     rdata2;

    fetch_stage fetch_stage_i (
        .clk         ( clk ),
        .rst         ( rst ),
        .stall       ( fetch_stall ),
        .redirect    ( redirect ),
        .redirect_pc ( redirect_pc ),
        .imem_req    ( imem_req ),
        .imem_rdata  ( imem_rdata ),
        .fetch_out   ( fetch_out )
    );

    decode_stage decode_stage_i (
        .clk         ( clk ),
        .rst         ( rst ),
        .stall       ( decode_stall ),
        .fetch_in    ( fetch_out ),
        .rs1         ( rs1 ),
        .rs2         ( rs2 ),
        .rdata1      ( rdata1 ),
        .rdata2      ( rdata2 ),
        .exec_in     ( exec_out ),   // interlock looks at execute's result too
        .decode_out  ( decode_out ),
        .fetch_stall ( fetch_stall ),
        .redirect    ( redirect ),
        .redirect_pc ( redirect_pc )
    );

    execute_stage execute_stage_i (
        .clk          ( clk ),
        .rst          ( rst ),
        .stall        ( exec_stall ),
        .decode_in    ( decode_out ),
        .exec_out     ( exec_out ),
        .decode_stall ( decode_stall )
    );

    writeback_stage writeback_stage_i (
        .clk           ( clk ),
        .rst           ( rst ),
        .exec_in       ( exec_out ),
        .exec_stall    ( exec_stall ),
        .wr            ( wr ),
        .retire_valid  ( retire_valid ),
        .retire        ( retire ),
        .retire_credit ( retire_credit )
    );

    register_file register_file_i (
        .clk    ( clk ),
        .rst    ( rst ),
        .rs1    ( rs1 ),
        .rs2    ( rs2 ),
        .rdata1 ( rdata1 ),
        .rdata2 ( rdata2 ),
        .wr     ( wr )
    );

endmodule

`default_nettype wire

//--- writeback_stage.sv
`timescale 1ns/100ps
`default_nettype none

`include "cpu_config.svh"

module writeback_stage import pipe_pkg::*; (
    input  wire              clk,
    input  wire              rst,
    input  wire exec_out_t   exec_in,
    output logic             exec_stall,
    output reg_write_t       wr,
    output logic             retire_valid,
    output retire_t          retire,
    input  wire              retire_credit
);
    localparam int CREDIT_BITS = $clog2(`RETIRE_CREDITS + 1);

    logic [CREDIT_BITS-1:0] credits;
    logic                   has_credit;

    assign has_credit   = credits != '0;
    assign retire_valid = exec_in.valid && has_credit;
    assign exec_stall   = exec_in.valid && !has_credit;

    assign retire = '{pc: exec_in.pc, rd: exec_in.rd, wen: exec_in.wen, data: exec_in.result};

    // regfile write lands on the retire edge
    assign wr = '{en: retire_valid && exec_in.wen, addr: exec_in.rd, data: exec_in.result};

    always_ff @(posedge clk) begin
        if (!rst) begin
            credits <= CREDIT_BITS'(`RETIRE_CREDITS);
        end else begin
            case ({retire_credit, retire_valid})
                2'b10: credits <= credits + 1'b1;
                2'b01: credits <= credits - 1'b1;
                default: credits <= credits;   // none, or one in and one out
            endcase
        end
    end

    assert property (@(posedge clk) disable iff (!rst)
        credits <= CREDIT_BITS'(`RETIRE_CREDITS));

    // a result waiting for credit is held unchanged
    assert property (@(posedge clk) disable iff (!rst)
        exec_stall |=> $stable(exec_in));

endmodule

`default_nettype wire

//--- execute_stage.sv
`timescale 1ns/100ps
`default_nettype none

`include "cpu_config.svh"

module execute_stage import pipe_pkg::*; (
    input  wire                clk,
    input  wire                rst,
    input  wire                stall,
    input  wire decode_out_t   decode_in,
    output exec_out_t          exec_out,
    output logic               decode_stall
);
    logic [`XLEN-1:0] result;

    always_comb begin
        case (decode_in.alu_op)
            ALU_ADD: begin
                result = decode_in.a + decode_in.b;
            end
            ALU_SUB: begin
                result = decode_in.a - decode_in.b;
            end
            ALU_AND: begin
                result = decode_in.a & decode_in.b;
            end
            ALU_OR: begin
                result = decode_in.a | decode_in.b;
            end
            ALU_XOR: begin
                result = decode_in.a ^ decode_in.b;
            end
            ALU_SLT: begin
                result = {{(`XLEN-1){1'b0}}, $signed(decode_in.a) < $signed(decode_in.b)};
            end
            default: begin
                result = decode_in.b;   // pass_b
            end
        endcase
    end

    // no buffer here, so writeback's stall goes straight to decode
    assign decode_stall = stall;

    always_ff @(posedge clk) begin
        if (!rst) begin
            exec_out.valid <= 1'b0;
        end else if (!stall) begin
            exec_out <= '{valid: decode_in.valid,
                          pc: decode_in.pc,
                          rd: decode_in.rd,
                          wen: decode_in.wen,
                          result: result};
        end
    end

endmodule

`default_nettype wire

//--- decode_stage.sv
`timescale 1ns/100ps
`default_nettype none

`include "cpu_config.svh"

module decode_stage import isa_pkg::*, pipe_pkg::*; (
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   stall,
    input  wire fetch_out_t       fetch_in,
    output logic [`REG_BITS-1:0]  rs1,
    output logic [`REG_BITS-1:0]  rs2,
    input  wire [`XLEN-1:0]       rdata1,
    input  wire [`XLEN-1:0]       rdata2,
    input  wire exec_out_t        exec_in,
    output decode_out_t           decode_out,
    output logic                  fetch_stall,
    output logic                  redirect,
    output logic [`XLEN-1:0]      redirect_pc
);
    instr_u           iw;
    decode_out_t      nxt;
    logic [`XLEN-1:0] imm_i;
    logic [`XLEN-1:0] imm_u;
    logic [`XLEN-1:0] imm_j;
    logic             use_rs1;
    logic             use_rs2;
    logic             is_jal;
    logic             known;
    logic             contended;

    // register still owed by an instruction further down the pipe
    function automatic logic in_flight(input logic [`REG_BITS-1:0] r,
                                       input decode_out_t d,
                                       input exec_out_t e);
        logic hit_d;
        logic hit_e;
        hit_d = d.valid && d.wen && d.rd == r;
        hit_e = e.valid && e.wen && e.rd == r;
        return r != '0 && (hit_d || hit_e);
    endfunction

    assign iw  = fetch_in.instr;
    assign rs1 = iw.r.rs1;
    assign rs2 = iw.r.rs2;

    assign imm_i = {{(`XLEN-12){iw.i.imm[11]}}, iw.i.imm};
    assign imm_u = {iw.u.imm, 12'b0};
    assign imm_j = {{(`XLEN-21){iw.j.imm20}}, iw.j.imm20, iw.j.imm19_12,
                    iw.j.imm11, iw.j.imm10_1, 1'b0};

    always_comb begin
        use_rs1    = 1'b0;
        use_rs2    = 1'b0;
        is_jal     = 1'b0;
        known      = 1'b0;
        nxt.valid  = fetch_in.valid;
        nxt.pc     = fetch_in.pc;
        nxt.alu_op = ALU_ADD;
        nxt.a      = rdata1;
        nxt.b      = rdata2;
        nxt.rd     = iw.r.rd;
        case (iw.r.opcode)
            OPC_OP: begin
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                known   = 1'b1;
                case ({iw.r.funct7, iw.r.funct3})
                    {F7_BASE, F3_ADD_SUB}: nxt.alu_op = ALU_ADD;
                    {F7_SUB, F3_ADD_SUB}:  nxt.alu_op = ALU_SUB;
                    {F7_BASE, F3_AND}:     nxt.alu_op = ALU_AND;
                    {F7_BASE, F3_OR}:      nxt.alu_op = ALU_OR;
                    {F7_BASE, F3_XOR}:     nxt.alu_op = ALU_XOR;
                    {F7_BASE, F3_SLT}:     nxt.alu_op = ALU_SLT;
                    default:               known = 1'b0;
                endcase
            end
            OPC_OP_IMM: begin
                use_rs1 = 1'b1;
                known   = iw.i.funct3 == F3_ADD_SUB;   // addi only
                nxt.b   = imm_i;
            end
            OPC_LUI: begin
                known      = 1'b1;
                nxt.alu_op = ALU_PASS_B;
                nxt.b      = imm_u;
            end
            OPC_JAL: begin
                known      = 1'b1;
                is_jal     = 1'b1;
                nxt.alu_op = ALU_PASS_B;
                nxt.b      = fetch_in.pc + `XLEN'd4;   // link value
            end
            default: begin
                known = 1'b0;   // retires as a bubble
            end
        endcase
        nxt.wen   = known && nxt.rd != '0;
        contended = fetch_in.valid &&
                    ((use_rs1 && in_flight(iw.r.rs1, decode_out, exec_in)) ||
                     (use_rs2 && in_flight(iw.r.rs2, decode_out, exec_in)));
    end

    assign fetch_stall = stall || contended;
    assign redirect    = fetch_in.valid && is_jal && !stall;
    assign redirect_pc = fetch_in.pc + imm_j;

    always_ff @(posedge clk) begin
        if (!rst) begin
            decode_out.valid <= 1'b0;
        end else if (!stall) begin
            decode_out       <= nxt;
            decode_out.valid <= nxt.valid && !contended;
        end
    end

    // the jump leaves and fetch has nothing behind it next cycle
    assert property (@(posedge clk) disable iff (!rst)
        redirect |=> !fetch_in.valid);

endmodule

`default_nettype wire

//--- fetch_stage.sv
`timescale 1ns/100ps
`default_nettype none

`include "cpu_config.svh"

module fetch_stage import pipe_pkg::*; (
    input  wire               clk,
    input  wire               rst,
    input  wire               stall,
    input  wire               redirect,
    input  wire [`XLEN-1:0]   redirect_pc,
    output fetch_req_t        imem_req,
    input  wire [`XLEN-1:0]   imem_rdata,
    output fetch_out_t        fetch_out
);
    logic             run;
    logic [`XLEN-1:0] pc;          // next address to request
    logic             pending;     // response due this cycle
    logic [`XLEN-1:0] pending_pc;
    fetch_out_t       resp;
    fetch_out_t       held;        // response that arrived under stall

    assign imem_req = '{valid: run && !stall && !redirect, addr: pc};
    assign resp = '{valid: pending, pc: pending_pc, instr: imem_rdata};

    always_ff @(posedge clk) begin
        if (!rst) begin
            run     <= 1'b0;
            pc      <= `RESET_PC;
            pending <= 1'b0;
        end else begin
            run     <= 1'b1;
            pending <= imem_req.valid;
            if (redirect) begin
                pc <= redirect_pc;
            end else if (imem_req.valid) begin
                pc <= pc + `XLEN'd4;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (imem_req.valid) begin
            pending_pc <= pc;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            fetch_out.valid <= 1'b0;
            held.valid      <= 1'b0;
        end else if (redirect) begin   // drop everything behind the jump
            fetch_out.valid <= 1'b0;
            held.valid      <= 1'b0;
        end else if (!stall) begin
            fetch_out  <= held.valid ? held : resp;
            held.valid <= 1'b0;
        end else if (pending) begin
            held <= resp;
        end
    end

    // a parked word is never overwritten by a fresh response
    assert property (@(posedge clk) disable iff (!rst)
        held.valid |-> !pending);

endmodule

`default_nettype wire

//--- register_file.sv
`timescale 1ns/100ps
`default_nettype none

`include "cpu_config.svh"

module register_file import pipe_pkg::*; (
    input  wire                   clk,
    input  wire                   rst,
    input  wire [`REG_BITS-1:0]   rs1,
    input  wire [`REG_BITS-1:0]   rs2,
    output logic [`XLEN-1:0]      rdata1,
    output logic [`XLEN-1:0]      rdata2,
    input  wire reg_write_t       wr
);
    logic [`XLEN-1:0] regs [`REG_COUNT];

    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr.en && wr.addr != '0) begin   // x0 is never written
            regs[wr.addr] <= wr.data;
        end
    end

    // same-cycle write is not forwarded, decode interlocks instead
    assign rdata1 = regs[rs1];
    assign rdata2 = regs[rs2];

    // decode clears wen for rd x0, so no write ever targets it
    assert property (@(posedge clk) disable iff (!rst)
        wr.en |-> wr.addr != '0);

endmodule

`default_nettype wire

//--- pipe_pkg.sv
`default_nettype none

`include "cpu_config.svh"

package pipe_pkg;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASS_B   // lui and link value
    } alu_op_t;

    typedef struct packed {
        logic             valid;
        logic [`XLEN-1:0] addr;
    } fetch_req_t;

    typedef struct packed {
        logic             valid;
        logic [`XLEN-1:0] pc;
        logic [`XLEN-1:0] instr;
    } fetch_out_t;

    typedef struct packed {
        logic                 valid;
        logic [`XLEN-1:0]     pc;
        alu_op_t              alu_op;
        logic [`XLEN-1:0]     a;
        logic [`XLEN-1:0]     b;
        logic [`REG_BITS-1:0] rd;
        logic                 wen;
    } decode_out_t;

    typedef struct packed {
        logic                 valid;
        logic [`XLEN-1:0]     pc;
        logic [`REG_BITS-1:0] rd;
        logic                 wen;
        logic [`XLEN-1:0]     result;
    } exec_out_t;

    typedef struct packed {
        logic [`XLEN-1:0]     pc;
        logic [`REG_BITS-1:0] rd;
        logic                 wen;
        logic [`XLEN-1:0]     data;
    } retire_t;

    typedef struct packed {
        logic                 en;
        logic [`REG_BITS-1:0] addr;
        logic [`XLEN-1:0]     data;
    } reg_write_t;

endpackage

`default_nettype wire

//--- isa_pkg.sv
`default_nettype none

`include "cpu_config.svh"

package isa_pkg;

    // base opcodes, only OP, OP_IMM, LUI and JAL are executed
    typedef enum logic [6:0] {
        OPC_LOAD   = 7'b0000011,
        OPC_OP_IMM = 7'b0010011,
        OPC_AUIPC  = 7'b0010111,
        OPC_STORE  = 7'b0100011,
        OPC_OP     = 7'b0110011,
        OPC_LUI    = 7'b0110111,
        OPC_BRANCH = 7'b1100011,
        OPC_JALR   = 7'b1100111,
        OPC_JAL    = 7'b1101111,
        OPC_SYSTEM = 7'b1110011
    } opcode_t;

    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_SUB  = 7'b0100000;

    typedef struct packed {
        logic [6:0]           funct7;
        logic [`REG_BITS-1:0] rs2;
        logic [`REG_BITS-1:0] rs1;
        logic [2:0]           funct3;
        logic [`REG_BITS-1:0] rd;
        opcode_t              opcode;
    } r_format_t;

    typedef struct packed {
        logic [11:0]          imm;
        logic [`REG_BITS-1:0] rs1;
        logic [2:0]           funct3;
        logic [`REG_BITS-1:0] rd;
        opcode_t              opcode;
    } i_format_t;

    typedef struct packed {
        logic [19:0]          imm;   // bits 31:12 of the result
        logic [`REG_BITS-1:0] rd;
        opcode_t              opcode;
    } u_format_t;

    // J immediate is scrambled across the word
    typedef struct packed {
        logic                 imm20;
        logic [9:0]           imm10_1;
        logic                 imm11;
        logic [7:0]           imm19_12;
        logic [`REG_BITS-1:0] rd;
        opcode_t              opcode;
    } j_format_t;

    typedef union packed {
        r_format_t r;
        i_format_t i;
        u_format_t u;
        j_format_t j;
    } instr_u;

endpackage

`default_nettype wire

//--- cpu_config.svh
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// datapath and address width
`define XLEN 32

// architectural register file
`define REG_COUNT 32
`define REG_BITS 5

// first fetch address after reset
`define RESET_PC 32'h0000_0000

// consumer buffer depth seen by writeback
`define RETIRE_CREDITS 4

`endif
